/* rtl/vic_regs_defs.svh */
`ifndef VIC_REGS_DEFS_SVH
`define VIC_REGS_DEFS_SVH

`define VIC_NUM_SPRITES 8
`define VIC_ADDR_W 6
`define VIC_COLOR_W 4

// sprite positions, x low byte on even addresses
`define VIC_REG_SPRITE_X_0 6'h00
`define VIC_REG_SPRITE_Y_0 6'h01
`define VIC_REG_SPRITE_X_1 6'h02
`define VIC_REG_SPRITE_Y_1 6'h03
`define VIC_REG_SPRITE_X_2 6'h04
`define VIC_REG_SPRITE_Y_2 6'h05
`define VIC_REG_SPRITE_X_3 6'h06
`define VIC_REG_SPRITE_Y_3 6'h07
`define VIC_REG_SPRITE_X_4 6'h08
`define VIC_REG_SPRITE_Y_4 6'h09
`define VIC_REG_SPRITE_X_5 6'h0a
`define VIC_REG_SPRITE_Y_5 6'h0b
`define VIC_REG_SPRITE_X_6 6'h0c
`define VIC_REG_SPRITE_Y_6 6'h0d
`define VIC_REG_SPRITE_X_7 6'h0e
`define VIC_REG_SPRITE_Y_7 6'h0f
`define VIC_REG_SPRITE_X_BIT_8 6'h10
`define VIC_REG_SCREEN_CONTROL_1 6'h11
`define VIC_REG_RASTER_LINE 6'h12
`define VIC_REG_LIGHT_PEN_X 6'h13
`define VIC_REG_LIGHT_PEN_Y 6'h14
`define VIC_REG_SPRITE_ENABLE 6'h15
`define VIC_REG_SCREEN_CONTROL_2 6'h16
`define VIC_REG_SPRITE_EXPAND_Y 6'h17
`define VIC_REG_MEMORY_SETUP 6'h18
`define VIC_REG_INTERRUPT_STATUS 6'h19
`define VIC_REG_INTERRUPT_CONTROL 6'h1a
`define VIC_REG_SPRITE_PRIORITY 6'h1b
`define VIC_REG_SPRITE_MULTICOLOR_MODE 6'h1c
`define VIC_REG_SPRITE_EXPAND_X 6'h1d
`define VIC_REG_SPRITE_2_SPRITE_COLLISION 6'h1e
`define VIC_REG_SPRITE_2_DATA_COLLISION 6'h1f
`define VIC_REG_BORDER_COLOR 6'h20
`define VIC_REG_BACKGROUND_COLOR_0 6'h21
`define VIC_REG_BACKGROUND_COLOR_1 6'h22
`define VIC_REG_BACKGROUND_COLOR_2 6'h23
`define VIC_REG_BACKGROUND_COLOR_3 6'h24
`define VIC_REG_SPRITE_MULTI_COLOR_0 6'h25
`define VIC_REG_SPRITE_MULTI_COLOR_1 6'h26
`define VIC_REG_SPRITE_COLOR_0 6'h27
`define VIC_REG_SPRITE_COLOR_1 6'h28
`define VIC_REG_SPRITE_COLOR_2 6'h29
`define VIC_REG_SPRITE_COLOR_3 6'h2a
`define VIC_REG_SPRITE_COLOR_4 6'h2b
`define VIC_REG_SPRITE_COLOR_5 6'h2c
`define VIC_REG_SPRITE_COLOR_6 6'h2d
`define VIC_REG_SPRITE_COLOR_7 6'h2e
`define VIC_REG_LAST 6'h2e

`endif

/* rtl/vic_regs_pkg.sv */
`include "vic_regs_defs.svh"

package vic_regs_pkg;

        typedef logic [`VIC_COLOR_W-1:0] color_t;

        // one decoded bus access, strobes last a single cycle
        typedef struct packed {
                logic rd;
                logic wr;
                logic [`VIC_ADDR_W-1:0] addr;
                logic [7:0] data;
        } reg_access_t;

        typedef struct packed {
                logic [`VIC_NUM_SPRITES-1:0][8:0] x;
                logic [`VIC_NUM_SPRITES-1:0][7:0] y;
                color_t [`VIC_NUM_SPRITES-1:0] col;
                logic [`VIC_NUM_SPRITES-1:0] en;
                logic [`VIC_NUM_SPRITES-1:0] xe;
                logic [`VIC_NUM_SPRITES-1:0] ye;
                logic [`VIC_NUM_SPRITES-1:0] pri;
                logic [`VIC_NUM_SPRITES-1:0] mmc;
                color_t mc0;
                color_t mc1;
        } sprite_cfg_t;

        typedef struct packed {
                color_t ec;
                color_t b0c;
                color_t b1c;
                color_t b2c;
                color_t b3c;
                logic [2:0] xscroll;
                logic [2:0] yscroll;
                logic csel;
                logic rsel;
                logic den;
                logic bmm;
                logic ecm;
                logic mcm;
                logic res;
                logic [2:0] cb;
                logic [3:0] vm;
                logic [8:0] raster_irq_compare;
        } video_cfg_t;

        // bit order matches register 0x19/0x1a, rst in bit 0
        typedef struct packed {
                logic lp;
                logic mmc;
                logic mbc;
                logic rst;
        } irq_bits_t;

        typedef struct packed {
                logic phi;
                logic start_1;
                logic start_15;
                logic start_dav;
        } phase_t;

endpackage

/* rtl/bus_access.sv */
`include "vic_regs_defs.svh"

module bus_access (
        input logic clk_dot4x,
        input logic rst,
        input logic aec,
        input logic ce,
        input logic rw,
        input logic [`VIC_ADDR_W-1:0] adi,
        input logic [7:0] dbi,
        input vic_regs_pkg::phase_t phase,
        output vic_regs_pkg::reg_access_t acc
);

        logic acc_open;
        logic rd_done;

        assign acc_open = aec && !ce;

        // read flag rearms once the bus is released
        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        rd_done <= 1'b0;
                end else if (!acc_open) begin
                        rd_done <= 1'b0;
                end else if (rw) begin
                        rd_done <= 1'b1;
                end
        end

        assign acc.rd = acc_open && rw && !rd_done;
        // cpu data is valid at the dav point of the phase
        assign acc.wr = acc_open && !rw && phase.start_dav;
        assign acc.addr = adi;
        assign acc.data = dbi;

        a_rd_once: assert property (@(posedge clk_dot4x) disable iff (rst)
                acc.rd |=> !acc.rd);

endmodule

/* rtl/sprite_regs.sv */
`include "vic_regs_defs.svh"

module sprite_regs (
        input logic clk_dot4x,
        input logic rst,
        input vic_regs_pkg::reg_access_t acc,
        input vic_regs_pkg::phase_t phase,
        output vic_regs_pkg::sprite_cfg_t sprite,
        output logic sprite_crunch
);

        logic [`VIC_ADDR_W-1:0] col_off;
        logic is_pos;
        logic is_col;

        // 0x00..0x0f alternate x and y, colors sit at 0x27..0x2e
        assign is_pos = acc.addr < `VIC_REG_SPRITE_X_BIT_8;
        assign is_col = acc.addr >= `VIC_REG_SPRITE_COLOR_0 &&
                        acc.addr <= `VIC_REG_SPRITE_COLOR_7;
        assign col_off = acc.addr - `VIC_REG_SPRITE_COLOR_0;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        sprite <= '0;
                        sprite_crunch <= 1'b0;
                end else begin
                        // crunch must be seen before the end of the phase
                        if (phase.start_15) begin
                                sprite_crunch <= 1'b0;
                        end
                        if (acc.wr) begin
                                case (acc.addr)
                                        `VIC_REG_SPRITE_X_BIT_8: begin
                                                for (int i = 0; i < `VIC_NUM_SPRITES; i++) begin
                                                        sprite.x[i][8] <= acc.data[i];
                                                end
                                        end
                                        `VIC_REG_SPRITE_ENABLE: sprite.en <= acc.data;
                                        `VIC_REG_SPRITE_EXPAND_Y: begin
                                                sprite.ye <= acc.data;
                                                sprite_crunch <= 1'b1;
                                        end
                                        `VIC_REG_SPRITE_PRIORITY: sprite.pri <= acc.data;
                                        `VIC_REG_SPRITE_MULTICOLOR_MODE: sprite.mmc <= acc.data;
                                        `VIC_REG_SPRITE_EXPAND_X: sprite.xe <= acc.data;
                                        `VIC_REG_SPRITE_MULTI_COLOR_0:
                                                sprite.mc0 <= acc.data[`VIC_COLOR_W-1:0];
                                        `VIC_REG_SPRITE_MULTI_COLOR_1:
                                                sprite.mc1 <= acc.data[`VIC_COLOR_W-1:0];
                                        default: begin
                                                if (is_pos && acc.addr[0]) begin
                                                        sprite.y[acc.addr[3:1]] <= acc.data;
                                                end else if (is_pos) begin
                                                        sprite.x[acc.addr[3:1]][7:0] <= acc.data;
                                                end else if (is_col) begin
                                                        sprite.col[col_off[2:0]] <=
                                                                acc.data[`VIC_COLOR_W-1:0];
                                                end
                                        end
                                endcase
                        end
                end
        end

        a_crunch_drop: assert property (@(posedge clk_dot4x) disable iff (rst)
                phase.start_15 |=> !sprite_crunch);

endmodule

/* rtl/video_regs.sv */
`include "vic_regs_defs.svh"

module video_regs (
        input logic clk_dot4x,
        input logic rst,
        input vic_regs_pkg::reg_access_t acc,
        output vic_regs_pkg::video_cfg_t video
);

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        video <= '0;
                end else if (acc.wr) begin
                        case (acc.addr)
                                `VIC_REG_SCREEN_CONTROL_1: begin
                                        video.yscroll <= acc.data[2:0];
                                        video.rsel <= acc.data[3];
                                        video.den <= acc.data[4];
                                        video.bmm <= acc.data[5];
                                        video.ecm <= acc.data[6];
                                        // raster compare msb shares this register
                                        video.raster_irq_compare[8] <= acc.data[7];
                                end
                                `VIC_REG_RASTER_LINE:
                                        video.raster_irq_compare[7:0] <= acc.data;
                                `VIC_REG_SCREEN_CONTROL_2: begin
                                        video.xscroll <= acc.data[2:0];
                                        video.csel <= acc.data[3];
                                        video.mcm <= acc.data[4];
                                        video.res <= acc.data[5];
                                end
                                `VIC_REG_MEMORY_SETUP: begin
                                        // bit 0 is unused
                                        video.cb <= acc.data[3:1];
                                        video.vm <= acc.data[7:4];
                                end
                                `VIC_REG_BORDER_COLOR:
                                        video.ec <= acc.data[`VIC_COLOR_W-1:0];
                                `VIC_REG_BACKGROUND_COLOR_0:
                                        video.b0c <= acc.data[`VIC_COLOR_W-1:0];
                                `VIC_REG_BACKGROUND_COLOR_1:
                                        video.b1c <= acc.data[`VIC_COLOR_W-1:0];
                                `VIC_REG_BACKGROUND_COLOR_2:
                                        video.b2c <= acc.data[`VIC_COLOR_W-1:0];
                                `VIC_REG_BACKGROUND_COLOR_3:
                                        video.b3c <= acc.data[`VIC_COLOR_W-1:0];
                                default: begin
                                end
                        endcase
                end
        end

endmodule

/* rtl/irq_ctrl_regs.sv */
`include "vic_regs_defs.svh"

module irq_ctrl_regs (
        input logic clk_dot4x,
        input logic rst,
        input vic_regs_pkg::reg_access_t acc,
        input vic_regs_pkg::phase_t phase,
        output vic_regs_pkg::irq_bits_t irq_en,
        output vic_regs_pkg::irq_bits_t irq_ack
);

        logic ack_clr;

        // acks are dropped at the end of the high phase
        assign ack_clr = phase.start_15 && phase.phi;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        irq_en <= '0;
                        irq_ack <= '0;
                end else begin
                        if (ack_clr) begin
                                irq_ack <= '0;
                        end
                        if (acc.wr && acc.addr == `VIC_REG_INTERRUPT_STATUS) begin
                                // writing a one acknowledges that source
                                irq_ack <= acc.data[3:0];
                        end
                        if (acc.wr && acc.addr == `VIC_REG_INTERRUPT_CONTROL) begin
                                irq_en <= acc.data[3:0];
                        end
                end
        end

        a_ack_drop: assert property (@(posedge clk_dot4x) disable iff (rst)
                ack_clr |=> irq_ack == '0);

endmodule

/* rtl/read_port.sv */
`include "vic_regs_defs.svh"

module read_port (
        input logic clk_dot4x,
        input logic rst,
        input vic_regs_pkg::reg_access_t acc,
        input vic_regs_pkg::phase_t phase,
        input vic_regs_pkg::sprite_cfg_t sprite,
        input vic_regs_pkg::video_cfg_t video,
        input vic_regs_pkg::irq_bits_t irq_en,
        input vic_regs_pkg::irq_bits_t irq_status,
        input logic irq,
        input logic [8:0] raster_line,
        input logic [7:0] lpx,
        input logic [7:0] lpy,
        input logic [7:0] sprite_m2m,
        input logic [7:0] sprite_m2d,
        output logic [7:0] dbo,
        output logic m2m_clr,
        output logic m2d_clr
);

        logic [7:0] rd_data;
        logic [`VIC_ADDR_W-1:0] col_off;

        assign col_off = acc.addr - `VIC_REG_SPRITE_COLOR_0;

        // unused bits read back as ones
        always_comb begin
                rd_data = 8'hff;
                case (acc.addr)
                        `VIC_REG_SPRITE_X_BIT_8: begin
                                for (int i = 0; i < `VIC_NUM_SPRITES; i++) begin
                                        rd_data[i] = sprite.x[i][8];
                                end
                        end
                        `VIC_REG_SCREEN_CONTROL_1:
                                rd_data = {raster_line[8], video.ecm, video.bmm, video.den,
                                           video.rsel, video.yscroll};
                        `VIC_REG_RASTER_LINE: rd_data = raster_line[7:0];
                        `VIC_REG_LIGHT_PEN_X: rd_data = lpx;
                        `VIC_REG_LIGHT_PEN_Y: rd_data = lpy;
                        `VIC_REG_SPRITE_ENABLE: rd_data = sprite.en;
                        `VIC_REG_SCREEN_CONTROL_2:
                                rd_data = {2'b11, video.res, video.mcm, video.csel, video.xscroll};
                        `VIC_REG_SPRITE_EXPAND_Y: rd_data = sprite.ye;
                        `VIC_REG_MEMORY_SETUP: rd_data = {video.vm, video.cb, 1'b1};
                        // irq arrives already active high
                        `VIC_REG_INTERRUPT_STATUS: rd_data = {irq, 3'b111, irq_status};
                        `VIC_REG_INTERRUPT_CONTROL: rd_data = {4'hf, irq_en};
                        `VIC_REG_SPRITE_PRIORITY: rd_data = sprite.pri;
                        `VIC_REG_SPRITE_MULTICOLOR_MODE: rd_data = sprite.mmc;
                        `VIC_REG_SPRITE_EXPAND_X: rd_data = sprite.xe;
                        `VIC_REG_SPRITE_2_SPRITE_COLLISION: rd_data = sprite_m2m;
                        `VIC_REG_SPRITE_2_DATA_COLLISION: rd_data = sprite_m2d;
                        `VIC_REG_BORDER_COLOR: rd_data = {4'hf, video.ec};
                        `VIC_REG_BACKGROUND_COLOR_0: rd_data = {4'hf, video.b0c};
                        `VIC_REG_BACKGROUND_COLOR_1: rd_data = {4'hf, video.b1c};
                        `VIC_REG_BACKGROUND_COLOR_2: rd_data = {4'hf, video.b2c};
                        `VIC_REG_BACKGROUND_COLOR_3: rd_data = {4'hf, video.b3c};
                        `VIC_REG_SPRITE_MULTI_COLOR_0: rd_data = {4'hf, sprite.mc0};
                        `VIC_REG_SPRITE_MULTI_COLOR_1: rd_data = {4'hf, sprite.mc1};
                        default: begin
                                if (acc.addr < `VIC_REG_SPRITE_X_BIT_8) begin
                                        rd_data = acc.addr[0] ? sprite.y[acc.addr[3:1]] :
                                                  sprite.x[acc.addr[3:1]][7:0];
                                end else if (acc.addr >= `VIC_REG_SPRITE_COLOR_0 &&
                                             acc.addr <= `VIC_REG_LAST) begin
                                        rd_data = {4'hf, sprite.col[col_off[2:0]]};
                                end
                        end
                endcase
        end

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        dbo <= 8'hff;
                        m2m_clr <= 1'b0;
                        m2d_clr <= 1'b0;
                end else begin
                        // latch clears land on cycle 1 of the next low phase
                        if (phase.start_1 && !phase.phi) begin
                                m2m_clr <= 1'b0;
                                m2d_clr <= 1'b0;
                        end
                        if (acc.rd) begin
                                dbo <= rd_data;
                                if (acc.addr == `VIC_REG_SPRITE_2_SPRITE_COLLISION) begin
                                        m2m_clr <= 1'b1;
                                end
                                if (acc.addr == `VIC_REG_SPRITE_2_DATA_COLLISION) begin
                                        m2d_clr <= 1'b1;
                                end
                        end
                end
        end

endmodule

/* rtl/vic_registers.sv */
`include "vic_regs_defs.svh"

module vic_registers (
        input logic clk_dot4x,
        input logic rst,
        input logic aec,
        input logic ce,
        input logic rw,
        input logic [`VIC_ADDR_W-1:0] adi,
        input logic [7:0] dbi,
        input vic_regs_pkg::phase_t phase,
        input logic irq,
        input vic_regs_pkg::irq_bits_t irq_status,
        input logic [8:0] raster_line,
        input logic [7:0] lpx,
        input logic [7:0] lpy,
        input logic [7:0] sprite_m2m,
        input logic [7:0] sprite_m2d,
        output logic [7:0] dbo,
        output vic_regs_pkg::sprite_cfg_t sprite,
        output vic_regs_pkg::video_cfg_t video,
        output vic_regs_pkg::irq_bits_t irq_en,
        output vic_regs_pkg::irq_bits_t irq_ack,
        output logic sprite_crunch,
        output logic m2m_clr,
        output logic m2d_clr
);

        vic_regs_pkg::reg_access_t acc;

        bus_access i_bus_access (
                .clk_dot4x(clk_dot4x), .rst(rst), .aec(aec), .ce(ce), .rw(rw),
                .adi(adi), .dbi(dbi), .phase(phase), .acc(acc)
        );

        sprite_regs i_sprite_regs (
                .clk_dot4x(clk_dot4x), .rst(rst), .acc(acc), .phase(phase),
                .sprite(sprite), .sprite_crunch(sprite_crunch)
        );

        video_regs i_video_regs (
                .clk_dot4x(clk_dot4x), .rst(rst), .acc(acc), .video(video)
        );

        irq_ctrl_regs i_irq_ctrl_regs (
                .clk_dot4x(clk_dot4x), .rst(rst), .acc(acc), .phase(phase),
                .irq_en(irq_en), .irq_ack(irq_ack)
        );

        read_port i_read_port (
                .clk_dot4x(clk_dot4x), .rst(rst), .acc(acc), .phase(phase),
                .sprite(sprite), .video(video), .irq_en(irq_en),
                .irq_status(irq_status), .irq(irq), .raster_line(raster_line),
                .lpx(lpx), .lpy(lpy), .sprite_m2m(sprite_m2m), .sprite_m2d(sprite_m2d),
                .dbo(dbo), .m2m_clr(m2m_clr), .m2d_clr(m2d_clr)
        );

endmodule

/* tb/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// each entry holds op, addr, arg and want
// arg is write data, a count for sweeps, {index, field} for checks or an event
typedef enum logic [3:0] {OP_WR, OP_RDP, OP_WRRD, OP_RDN, OP_CHK, OP_WAIT} op_e;
typedef enum logic [3:0] {
        F_DBO, F_SPR_X, F_SPR_COL, F_RASTER_CMP, F_SCREEN1, F_MEM,
        F_IRQ_EN, F_IRQ_ACK, F_CRUNCH, F_CLR_SNAP, F_CLR_NOW
} field_e;
typedef enum logic [7:0] {EV_ACK_CLR, EV_CLR, EV_S15} event_e;

typedef struct packed {
        op_e op;
        logic [5:0] addr;
        logic [7:0] arg;
        logic [15:0] want;
} vector_t;

string field_names [11] = '{"dbo", "sprite.x", "sprite.col", "video.raster_irq_compare",
        "video.screen_control_1", "video.memory_setup", "irq_en", "irq_ack",
        "sprite_crunch", "collision clear after read", "{m2m_clr, m2d_clr}"};

localparam logic [33:0] VECTORS [50] = '{
        {OP_CHK, 6'h00, 4'd0, F_DBO, 16'h00ff},
        // want holds the bits that read as one after a write and read back
        {OP_WRRD, 6'h00, 8'd17, 16'h0000},
        {OP_WRRD, 6'h15, 8'd1, 16'h0000},
        {OP_WRRD, 6'h16, 8'd1, 16'h00c0},
        {OP_WRRD, 6'h17, 8'd1, 16'h0000},
        {OP_WRRD, 6'h18, 8'd1, 16'h0001},
        {OP_WRRD, 6'h1a, 8'd1, 16'h00f0},
        {OP_WRRD, 6'h1b, 8'd3, 16'h0000},
        {OP_WRRD, 6'h20, 8'd15, 16'h00f0},
        // configuration outputs
        {OP_WR, 6'h06, 8'h5a, 16'h0000},
        {OP_WR, 6'h10, 8'h08, 16'h0000},
        {OP_CHK, 6'h00, 4'd3, F_SPR_X, 16'h015a},
        {OP_WR, 6'h11, 8'h9b, 16'h0000},
        {OP_WR, 6'h12, 8'h37, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_RASTER_CMP, 16'h0137},
        {OP_CHK, 6'h00, 4'd0, F_SCREEN1, 16'h001b},
        {OP_RDP, 6'h11, 8'h00, 16'h001b},
        {OP_WR, 6'h18, 8'hd6, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_MEM, 16'h006b},
        {OP_WR, 6'h2c, 8'h39, 16'h0000},
        {OP_CHK, 6'h00, 4'd5, F_SPR_COL, 16'h0009},
        {OP_WR, 6'h1a, 8'h35, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_IRQ_EN, 16'h0005},
        // read only registers keep showing their inputs
        {OP_WR, 6'h1e, 8'h00, 16'h0000},
        {OP_WR, 6'h1f, 8'h00, 16'h0000},
        {OP_RDP, 6'h12, 8'h00, 16'h0000},
        {OP_RDP, 6'h13, 8'h00, 16'h0000},
        {OP_RDP, 6'h14, 8'h00, 16'h0000},
        {OP_RDP, 6'h19, 8'h00, 16'h0000},
        {OP_RDP, 6'h1e, 8'h00, 16'h0000},
        {OP_RDP, 6'h1f, 8'h00, 16'h0000},
        {OP_RDN, 6'h2f, 8'd17, 16'h00ff},
        // interrupt acknowledge
        {OP_WR, 6'h19, 8'h3b, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_IRQ_ACK, 16'h000b},
        {OP_RDP, 6'h19, 8'h00, 16'h0000},
        {OP_WAIT, 6'h00, EV_ACK_CLR, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_IRQ_ACK, 16'h0000},
        // collision clears
        {OP_WAIT, 6'h00, EV_CLR, 16'h0000},
        {OP_RDP, 6'h1e, 8'h00, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_CLR_SNAP, 16'h0002},
        {OP_WAIT, 6'h00, EV_CLR, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_CLR_NOW, 16'h0000},
        {OP_RDP, 6'h1f, 8'h00, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_CLR_SNAP, 16'h0001},
        {OP_WAIT, 6'h00, EV_CLR, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_CLR_NOW, 16'h0000},
        // sprite crunch
        {OP_WR, 6'h17, 8'ha5, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_CRUNCH, 16'h0001},
        {OP_WAIT, 6'h00, EV_S15, 16'h0000},
        {OP_CHK, 6'h00, 4'd0, F_CRUNCH, 16'h0000}
};

`endif

/* tb/tb_vic_registers.sv */
`include "vic_regs_defs.svh"

module tb_vic_registers;
        timeunit 1ns;
        timeprecision 1ps;

        `include "tb_vectors.svh"

        logic clk_dot4x;
        logic rst;
        logic aec;
        logic ce;
        logic rw;
        logic [`VIC_ADDR_W-1:0] adi;
        logic [7:0] dbi;
        vic_regs_pkg::phase_t phase;
        logic irq;
        vic_regs_pkg::irq_bits_t irq_status;
        logic [8:0] raster_line;
        logic [7:0] lpx;
        logic [7:0] lpy;
        logic [7:0] sprite_m2m;
        logic [7:0] sprite_m2d;
        logic [7:0] dbo;
        vic_regs_pkg::sprite_cfg_t sprite;
        vic_regs_pkg::video_cfg_t video;
        vic_regs_pkg::irq_bits_t irq_en;
        vic_regs_pkg::irq_bits_t irq_ack;
        logic sprite_crunch;
        logic m2m_clr;
        logic m2d_clr;

        logic [3:0] phase_cnt;
        logic [1:0] clr_snap;
        int cycles;
        int cycle_limit;

        vic_registers i_dut (.*);

        initial begin
                clk_dot4x = 1'b0;
                forever #4 clk_dot4x = ~clk_dot4x;
        end

        // phi flips each time the 16 cycle counter wraps
        always @(negedge clk_dot4x) begin
                phase_cnt = phase_cnt + 4'd1;
                if (phase_cnt == 4'd0) begin
                        phase.phi = !phase.phi;
                end
                phase.start_1 = phase_cnt == 4'd1;
                phase.start_dav = phase_cnt == 4'd12;
                phase.start_15 = phase_cnt == 4'd15;
        end

        always @(posedge clk_dot4x) begin
                cycles = cycles + 1;
                if (cycles > cycle_limit) begin
                        $display("TESTBENCH FAILED");
                        $fatal(1, "timeout after %0d cycles, test table not finished", cycles);
                end
        end

        task automatic check_value(input string name, input logic [15:0] got,
                                   input logic [15:0] want);
                if (got !== want) begin
                        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "mismatch on %s", name);
                end
        endtask

        function automatic logic [7:0] rand_byte();
                logic [31:0] r;
                r = $urandom();
                return r[7:0];
        endfunction

        task automatic scramble_status();
                logic [31:0] r;
                r = $urandom();
                irq = r[0];
                irq_status = r[4:1];
                raster_line = r[13:5];
                lpx = rand_byte();
                lpy = rand_byte();
                sprite_m2m = rand_byte();
                sprite_m2d = rand_byte();
        endtask

        // holds the access until the posedge that carries start_dav
        task automatic write_bus(input logic [5:0] addr, input logic [7:0] data);
                aec = 1'b1;
                ce = 1'b0;
                rw = 1'b0;
                adi = addr;
                dbi = data;
                do @(posedge clk_dot4x); while (!phase.start_dav);
                @(negedge clk_dot4x);
                aec = 1'b0;
                ce = 1'b1;
                rw = 1'b1;
                @(negedge clk_dot4x);
        endtask

        // dbo must hold its first value while the status inputs change
        task automatic read_bus(input logic [5:0] addr, output logic [7:0] data);
                aec = 1'b1;
                ce = 1'b0;
                rw = 1'b1;
                adi = addr;
                @(negedge clk_dot4x);
                clr_snap = {m2m_clr, m2d_clr};
                scramble_status();
                repeat (3) @(negedge clk_dot4x);
                data = dbo;
                aec = 1'b0;
                ce = 1'b1;
                @(negedge clk_dot4x);
        endtask

        task automatic wait_event(input logic [7:0] ev);
                logic hit;
                hit = 1'b0;
                while (!hit) begin
                        @(posedge clk_dot4x);
                        case (ev)
                                EV_ACK_CLR: hit = phase.start_15 && phase.phi;
                                EV_CLR: hit = phase.start_1 && !phase.phi;
                                default: hit = phase.start_15;
                        endcase
                end
                @(negedge clk_dot4x);
        endtask

        function automatic logic [15:0] field_value(input logic [7:0] sel);
                logic [15:0] v;
                v = '0;
                case (sel[3:0])
                        F_DBO: v[7:0] = dbo;
                        F_SPR_X: v[8:0] = sprite.x[sel[6:4]];
                        F_SPR_COL: v[3:0] = sprite.col[sel[6:4]];
                        F_RASTER_CMP: v[8:0] = video.raster_irq_compare;
                        F_SCREEN1: v[6:0] = {video.ecm, video.bmm, video.den, video.rsel,
                                             video.yscroll};
                        F_MEM: v[6:0] = {video.vm, video.cb};
                        F_IRQ_EN: v[3:0] = irq_en;
                        F_IRQ_ACK: v[3:0] = irq_ack;
                        F_CRUNCH: v[0] = sprite_crunch;
                        F_CLR_SNAP: v[1:0] = clr_snap;
                        F_CLR_NOW: v[1:0] = {m2m_clr, m2d_clr};
                        default: v = '1;
                endcase
                return v;
        endfunction

        // readback of the pass-through registers follows the status inputs
        function automatic logic [7:0] read_expected(input logic [5:0] addr,
                                                     input logic [15:0] want);
                case (addr)
                        `VIC_REG_SCREEN_CONTROL_1: return {raster_line[8], want[6:0]};
                        `VIC_REG_RASTER_LINE: return raster_line[7:0];
                        `VIC_REG_LIGHT_PEN_X: return lpx;
                        `VIC_REG_LIGHT_PEN_Y: return lpy;
                        `VIC_REG_INTERRUPT_STATUS: return {irq, 3'b111, irq_status};
                        `VIC_REG_SPRITE_2_SPRITE_COLLISION: return sprite_m2m;
                        `VIC_REG_SPRITE_2_DATA_COLLISION: return sprite_m2d;
                        default: return want[7:0];
                endcase
        endfunction

        initial begin
                vector_t v;
                logic [5:0] addr;
                logic [7:0] data;
                logic [7:0] got;
                logic [7:0] want;
                void'($urandom(32'hb4ff_c884));
                rst = 1'b1;
                aec = 1'b0;
                ce = 1'b1;
                rw = 1'b1;
                adi = '0;
                dbi = '0;
                phase = '0;
                phase_cnt = '0;
                clr_snap = '0;
                cycles = 0;
                scramble_status();
                cycle_limit = 200;
                foreach (VECTORS[i]) begin
                        v = VECTORS[i];
                        cycle_limit += (v.op == OP_WRRD || v.op == OP_RDN) ? 64 * v.arg : 64;
                end
                repeat (2) @(posedge clk_dot4x);
                @(negedge clk_dot4x);
                rst = 1'b0;
                foreach (VECTORS[i]) begin
                        v = VECTORS[i];
                        case (v.op)
                                OP_WR: write_bus(v.addr, v.arg);
                                OP_RDP: begin
                                        scramble_status();
                                        want = read_expected(v.addr, v.want);
                                        read_bus(v.addr, got);
                                        check_value($sformatf("dbo at 0x%h", v.addr),
                                                    {8'h00, got}, {8'h00, want});
                                end
                                OP_WRRD: begin
                                        addr = v.addr;
                                        repeat (v.arg) begin
                                                data = rand_byte();
                                                write_bus(addr, data);
                                                read_bus(addr, got);
                                                check_value($sformatf("dbo at 0x%h", addr),
                                                            {8'h00, got},
                                                            {8'h00, data | v.want[7:0]});
                                                addr = addr + 6'd1;
                                        end
                                end
                                OP_RDN: begin
                                        addr = v.addr;
                                        repeat (v.arg) begin
                                                read_bus(addr, got);
                                                check_value($sformatf("dbo at 0x%h", addr),
                                                            {8'h00, got}, v.want);
                                                addr = addr + 6'd1;
                                        end
                                end
                                OP_CHK: check_value(field_names[v.arg[3:0]], field_value(v.arg),
                                                    v.want);
                                OP_WAIT: wait_event(v.arg);
                                default: begin
                                        $display("TESTBENCH FAILED");
                                        $fatal(1, "unknown operation in entry %0d", i);
                                end
                        endcase
                end
                $display("TESTBENCH PASSED");
                $finish;
        end

endmodule

/* flist.f */
+incdir+rtl
+incdir+tb
rtl/vic_regs_pkg.sv
rtl/bus_access.sv
rtl/sprite_regs.sv
rtl/video_regs.sv
rtl/irq_ctrl_regs.sv
rtl/read_port.sv
rtl/vic_registers.sv
tb/tb_vic_registers.sv

/* Bender.yml */
package:
  name: vic_registers

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vic_regs_pkg.sv
      - rtl/bus_access.sv
      - rtl/sprite_regs.sv
      - rtl/video_regs.sv
      - rtl/irq_ctrl_regs.sv
      - rtl/read_port.sv
      - rtl/vic_registers.sv
  - target: test
    include_dirs:
      - rtl
      - tb
    files:
      - tb/tb_vic_registers.sv
